//--- ppu_pkg.sv
// background path only (no sprites or window); all VRAM addresses are full CPU addresses
package ppu_pkg;

    // lcd register block, FF46 is not mapped here
    localparam logic [15:0] addr_lcdc = 16'hff40;
    localparam logic [15:0] addr_stat = 16'hff41;
    localparam logic [15:0] addr_scy  = 16'hff42;
    localparam logic [15:0] addr_scx  = 16'hff43;
    localparam logic [15:0] addr_ly   = 16'hff44;
    localparam logic [15:0] addr_lyc  = 16'hff45;
    localparam logic [15:0] addr_bgp  = 16'hff47;

    localparam logic [15:0] map_base_lo        = 16'h9800;
    localparam logic [15:0] map_base_hi        = 16'h9c00;  // LCDC bit 3 set
    localparam logic [15:0] tile_base_unsigned = 16'h8000;  // LCDC bit 4 set
    localparam logic [15:0] tile_base_signed   = 16'h9000;

    // line timing in dots, one dot per clock
    localparam logic [8:0] dots_per_line = 9'd456;
    localparam logic [8:0] scan_dots     = 9'd80;
    localparam logic [7:0] visible_lines = 8'd144;
    localparam logic [7:0] last_line     = 8'd153;
    localparam logic [7:0] visible_width = 8'd160;

    typedef enum logic [1:0] {
        h_blank = 2'd0,
        v_blank = 2'd1,
        scan    = 2'd2,
        draw    = 2'd3
    } ppu_mode_t;

    typedef struct packed {
        logic [7:0] lcdc;
        logic [7:0] scx;
        logic [7:0] scy;
        logic [7:0] lyc;
        logic [7:0] bgp;   // held for the CPU, never applied to pixels
    } lcd_cfg_t;

    // one tile row as two bit-planes
    typedef struct packed {
        logic [7:0] lo;
        logic [7:0] hi;
    } tile_row_t;

    typedef union packed {
        logic [7:0]        u;   // 8000 addressing
        logic signed [7:0] s;   // 8800 addressing, relative to 9000
    } tile_num_u;

endpackage

//--- ppu_regs.sv
// rdata is combinational and reads FF unless rd is high; LY and STAT bits 2:0 are read only
module ppu_regs
    import ppu_pkg::*;
#(
    parameter bit boot_defaults = 1'b0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] addr,
    input  logic        wr,
    input  logic        rd,
    input  logic [7:0]  wdata,
    input  logic [7:0]  ly,
    input  ppu_mode_t   mode,
    input  logic        coincidence,
    output logic [7:0]  rdata,
    output lcd_cfg_t    cfg,
    output logic        irq_stat
);

    lcd_cfg_t   cfg_q;
    logic [3:0] stat_en;      // STAT bits 6:3
    logic       stat_src;
    logic       stat_src_q;

    assign cfg = cfg_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q      <= '0;
            cfg_q.lcdc <= boot_defaults ? 8'h91 : 8'h00;
            stat_en    <= '0;
        end else if (wr) begin
            case (addr)
                addr_lcdc: cfg_q.lcdc <= wdata;
                addr_stat: stat_en    <= wdata[6:3];
                addr_scy:  cfg_q.scy  <= wdata;
                addr_scx:  cfg_q.scx  <= wdata;   // bits 2:0 kept but unused
                addr_lyc:  cfg_q.lyc  <= wdata;
                addr_bgp:  cfg_q.bgp  <= wdata;
                default: ;                        // LY writes fall here too
            endcase
        end
    end

    // OR of the enabled sources, silent while the LCD is off
    assign stat_src = cfg_q.lcdc[7]
                   && ((stat_en[3] && coincidence)
                    || (stat_en[0] && mode == h_blank)
                    || (stat_en[2] && mode == scan)
                    || (stat_en[1] && mode == v_blank));

    always_ff @(posedge clk) begin
        if (rst) begin
            stat_src_q <= 1'b0;
            irq_stat   <= 1'b0;
        end else begin
            stat_src_q <= stat_src;
            irq_stat   <= stat_src && !stat_src_q;  // rising edge only
        end
    end

    always_comb begin
        rdata = 8'hff;
        if (rd) begin
            case (addr)
                addr_lcdc: rdata = cfg_q.lcdc;
                addr_stat: rdata = {1'b1, stat_en, coincidence, mode};
                addr_scy:  rdata = cfg_q.scy;
                addr_scx:  rdata = cfg_q.scx;
                addr_ly:   rdata = ly;
                addr_lyc:  rdata = cfg_q.lyc;
                addr_bgp:  rdata = cfg_q.bgp;
                default:   rdata = 8'hff;
            endcase
        end
    end

endmodule

//--- ppu_timing.sv
// dots and lines run only while LCDC bit 7 is set; the draw phase lasts until line_done arrives
module ppu_timing
    import ppu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  lcd_cfg_t   cfg,
    input  logic       line_done,
    output ppu_mode_t  mode,
    output logic [7:0] ly,
    output logic       coincidence,
    output logic       line_start,
    output logic       irq_vblank
);

    logic [8:0] dot;
    logic       lcd_on;
    logic       visible;
    logic       line_end;
    logic       scan_end;
    logic       drawing;

    assign lcd_on      = cfg.lcdc[7];
    assign visible     = ly < visible_lines;
    assign line_end    = dot == dots_per_line - 9'd1;
    assign scan_end    = visible && dot == scan_dots - 9'd1;
    assign coincidence = ly == cfg.lyc;

    always_ff @(posedge clk) begin
        if (rst || !lcd_on) begin
            dot <= '0;
            ly  <= '0;
        end else if (line_end) begin
            dot <= '0;
            ly  <= (ly == last_line) ? 8'd0 : ly + 8'd1;
        end else begin
            dot <= dot + 9'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !lcd_on) begin
            drawing    <= 1'b0;
            line_start <= 1'b0;
            irq_vblank <= 1'b0;
        end else begin
            line_start <= scan_end;                                   // high on first draw dot
            irq_vblank <= line_end && ly == visible_lines - 8'd1;    // 143 -> 144
            if (scan_end)
                drawing <= 1'b1;
            else if (line_done || line_end)
                drawing <= 1'b0;
        end
    end

    always_comb begin
        if (!lcd_on)
            mode = h_blank;
        else if (!visible)
            mode = v_blank;
        else if (dot < scan_dots)
            mode = scan;
        else if (drawing)
            mode = draw;
        else
            mode = h_blank;
    end

    a_ly_range: assert property (@(posedge clk) disable iff (rst) ly <= last_line);

endmodule

//--- ppu_bg_fetch.sv
// whole-tile scroll only (SCX bits 2:0 ignored); VRAM must return data one cycle after the read
module ppu_bg_fetch
    import ppu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  lcd_cfg_t    cfg,
    input  logic [7:0]  ly,
    input  logic        line_start,
    input  logic        row_take,
    input  logic [7:0]  vram_data,
    output logic        vram_rd,
    output logic [15:0] vram_addr,
    output tile_row_t   row,
    output logic        row_ready
);

    localparam logic [4:0] tiles_per_line = 5'(visible_width / 8);

    typedef enum logic [2:0] {
        f_idle,
        f_map,    // map entry read issued
        f_lo,     // tile number back, lo plane read issued
        f_hi,     // lo plane back, hi plane read issued
        f_done    // hi plane back
    } fetch_state_t;

    fetch_state_t state;
    logic [4:0]   col;        // tile column within the line
    logic [7:0]   bg_y;
    logic [4:0]   map_col;
    logic [15:0]  map_addr;
    logic [15:0]  lo_addr;
    logic [15:0]  hi_addr;
    tile_num_u    tile_num;

    assign bg_y     = ly + cfg.scy;          // wraps at 256
    assign map_col  = col + cfg.scx[7:3];    // wraps at 32
    assign map_addr = (cfg.lcdc[3] ? map_base_hi : map_base_lo)
                    + {6'd0, bg_y[7:3], map_col};

    assign tile_num.u = vram_data;

    always_comb begin
        if (cfg.lcdc[4])
            lo_addr = tile_base_unsigned + {4'd0, tile_num.u, 4'd0};
        else
            lo_addr = tile_base_signed + {{4{tile_num.s[7]}}, tile_num.s, 4'd0};
        lo_addr = lo_addr + {12'd0, bg_y[2:0], 1'b0};
    end

    always_ff @(posedge clk) begin
        if (rst || line_start || !cfg.lcdc[7]) begin
            state     <= f_idle;
            col       <= line_start ? 5'd0 : tiles_per_line;
            row_ready <= 1'b0;
        end else begin
            if (row_take)
                row_ready <= 1'b0;
            case (state)
                f_idle: if (col != tiles_per_line && !row_ready) state <= f_map;
                f_map: begin
                    col   <= col + 5'd1;
                    state <= f_lo;
                end
                f_lo:   state <= f_hi;
                f_hi:   state <= f_done;
                f_done: begin
                    row_ready <= 1'b1;   // held until the shifter takes it
                    state     <= f_idle;
                end
                default: state <= f_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == f_lo)
            hi_addr <= lo_addr + 16'd1;
        if (state == f_hi)
            row.lo <= cfg.lcdc[0] ? vram_data : 8'h00;   // bg off gives colour 0
        if (state == f_done)
            row.hi <= cfg.lcdc[0] ? vram_data : 8'h00;
    end

    assign vram_rd = state inside {f_map, f_lo, f_hi};

    always_comb begin
        case (state)
            f_lo:    vram_addr = lo_addr;
            f_hi:    vram_addr = hi_addr;
            default: vram_addr = map_addr;
        endcase
    end

endmodule

//--- ppu_px_shift.sv
// emits raw two-bit indices, MSB first; stops after visible_width pixels until the next line_start
module ppu_px_shift
    import ppu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       line_start,
    input  tile_row_t  row,
    input  logic       row_ready,
    output logic       row_take,
    output logic [1:0] px,
    output logic       px_valid,
    output logic       line_done
);

    tile_row_t  planes;
    logic [3:0] left;     // pixels still in the planes
    logic [7:0] count;    // pixels sent on this line

    assign px_valid = left != 4'd0;
    assign px       = {planes.hi[7], planes.lo[7]};
    assign row_take = !px_valid && row_ready && count < visible_width;

    always_ff @(posedge clk) begin
        if (rst || line_start) begin
            left      <= '0;
            count     <= rst ? visible_width : 8'd0;   // idle until the first line
            line_done <= 1'b0;
        end else begin
            line_done <= px_valid && count == visible_width - 8'd1;
            if (row_take) begin
                left <= 4'd8;
            end else if (px_valid) begin
                left  <= left - 4'd1;
                count <= count + 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_take) begin
            planes <= row;
        end else if (px_valid) begin
            planes.lo <= {planes.lo[6:0], 1'b0};
            planes.hi <= {planes.hi[6:0], 1'b0};
        end
    end

    // a loaded row goes out as eight back-to-back pixels with no reload in between
    a_full_row: assert property (@(posedge clk) disable iff (rst || line_start)
        row_take |=> left == 4'd8 ##7 left == 4'd1);

endmodule

//--- ppu_top.sv
// boot_defaults starts with LCDC 91; vram_data must hold the byte addressed at the previous edge
module ppu_top
    import ppu_pkg::*;
#(
    parameter bit boot_defaults = 1'b0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] addr,
    input  logic        wr,
    input  logic        rd,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,
    output logic        vram_rd,
    output logic [15:0] vram_addr,
    input  logic [7:0]  vram_data,
    output logic [1:0]  px,
    output logic        px_valid,
    output logic        irq_vblank,
    output logic        irq_stat,
    output ppu_mode_t   mode
);

    lcd_cfg_t   cfg;
    tile_row_t  row;
    logic [7:0] ly;
    logic       coincidence;
    logic       line_start;
    logic       line_done;
    logic       row_ready;
    logic       row_take;

    ppu_regs #(.boot_defaults(boot_defaults)) ppu_regs_inst (
        .clk(clk), .rst(rst), .addr(addr), .wr(wr), .rd(rd), .wdata(wdata),
        .ly(ly), .mode(mode), .coincidence(coincidence),
        .rdata(rdata), .cfg(cfg), .irq_stat(irq_stat)
    );

    ppu_timing ppu_timing_inst (
        .clk(clk), .rst(rst), .cfg(cfg), .line_done(line_done),
        .mode(mode), .ly(ly), .coincidence(coincidence),
        .line_start(line_start), .irq_vblank(irq_vblank)
    );

    ppu_bg_fetch ppu_bg_fetch_inst (
        .clk(clk), .rst(rst), .cfg(cfg), .ly(ly), .line_start(line_start),
        .row_take(row_take), .vram_data(vram_data), .vram_rd(vram_rd),
        .vram_addr(vram_addr), .row(row), .row_ready(row_ready)
    );

    ppu_px_shift ppu_px_shift_inst (
        .clk(clk), .rst(rst), .line_start(line_start), .row(row), .row_ready(row_ready),
        .row_take(row_take), .px(px), .px_valid(px_valid), .line_done(line_done)
    );

    // the fetcher only touches VRAM inside the draw phase set by the timing block
    a_vram_in_draw: assert property (@(posedge clk) disable iff (rst || !cfg.lcdc[7])
        vram_rd |-> mode == draw);

endmodule

//--- ppu_tb_clk.sv
// free-running clock for the testbench, starts low; period given in simulator time units
module ppu_tb_clk #(
    parameter int period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

//--- ppu_tb.sv
// drives inputs on the falling edge and samples there too; VRAM model covers 8000..9FFF only
module ppu_tb
    import ppu_pkg::*;
();

    localparam int n_tests        = 6;
    localparam int frame_cycles   = 154 * 456;
    localparam int timeout_cycles = (n_tests + 2) * frame_cycles + 1000;

    typedef struct packed {
        logic [7:0] lcdc;
        logic [7:0] scx;
        logic [7:0] scy;
        logic [7:0] lyc;
        logic [7:0] stat_en;
    } test_t;

    // lcdc, scx, scy, lyc, stat enables
    string names [n_tests] = '{"map_lo_tiles_8000", "map_hi_tiles_8800", "scroll_wrap",
                               "bg_disabled", "lcd_off", "lyc_in_vblank"};
    test_t tests [n_tests] = '{{8'h91, 8'h00, 8'h00, 8'd10,  8'h40},
                               {8'h89, 8'h28, 8'h13, 8'd100, 8'h40},
                               {8'h99, 8'hf3, 8'hf0, 8'd143, 8'h00},
                               {8'h98, 8'h08, 8'h05, 8'd0,   8'h40},
                               {8'h11, 8'h00, 8'h00, 8'd0,   8'h40},
                               {8'h81, 8'h10, 8'h77, 8'd150, 8'h40}};

    logic        clk;
    logic        rst;
    logic [15:0] addr;
    logic        wr;
    logic        rd;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        vram_rd;
    logic [15:0] vram_addr;
    logic [7:0]  vram_data = 8'h00;
    logic [1:0]  px;
    logic        px_valid;
    logic        irq_vblank;
    logic        irq_stat;
    ppu_mode_t   mode;
    logic [7:0]  vram [8192];
    int          cycles = 0;

    ppu_tb_clk clk_gen (.clk(clk));

    ppu_top ppu_top_inst (
        .clk(clk), .rst(rst), .addr(addr), .wr(wr), .rd(rd), .wdata(wdata), .rdata(rdata),
        .vram_rd(vram_rd), .vram_addr(vram_addr), .vram_data(vram_data), .px(px),
        .px_valid(px_valid), .irq_vblank(irq_vblank), .irq_stat(irq_stat), .mode(mode)
    );

    always @(posedge clk) begin
        if (vram_rd)
            vram_data <= vram[vram_addr[12:0]];  // one cycle read latency
    end

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_now(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles)
            fail_now($sformatf("timeout: no end of test after %0d cycles", timeout_cycles));
    end

    task automatic check_byte(string what, logic [7:0] exp, logic [7:0] act);
        if (act !== exp)
            fail_now($sformatf("FAIL %s expected %02h actual %02h", what, exp, act));
    endtask

    task automatic check_px(string what, logic [1:0] exp, logic [1:0] act);
        if (act !== exp)
            fail_now($sformatf("FAIL %s expected %0d actual %0d", what, exp, act));
    endtask

    task automatic check_mode(string what, ppu_mode_t exp, ppu_mode_t act);
        if (act !== exp)
            fail_now($sformatf("FAIL %s expected %s actual %s", what, exp.name(), act.name()));
    endtask

    // background pixel from VRAM, scroll X in whole tiles
    function automatic logic [1:0] ref_px(test_t t, int line, int x);
        logic [7:0]  bg_y;
        logic [15:0] map_addr;
        logic [15:0] tile_addr;
        logic [7:0]  tnum;
        logic [2:0]  bit_idx;
        logic [7:0]  lo;
        logic [7:0]  hi;
        bg_y     = 8'(line) + t.scy;
        map_addr = (t.lcdc[3] ? 16'h9c00 : 16'h9800) + 16'(bg_y[7:3]) * 16'd32
                 + 16'((x / 8 + int'(t.scx[7:3])) % 32);
        tnum = vram[map_addr[12:0]];
        if (t.lcdc[4])
            tile_addr = 16'h8000 + 16'(tnum) * 16'd16;
        else
            tile_addr = 16'(36864 + int'($signed(tnum)) * 16);  // signed around 9000
        tile_addr = tile_addr + 16'(bg_y[2:0]) * 16'd2;
        lo        = vram[tile_addr[12:0]];
        hi        = vram[13'(tile_addr[12:0] + 13'd1)];
        bit_idx   = 3'(7 - x % 8);
        if (!t.lcdc[0])
            return 2'b00;
        return {hi[bit_idx], lo[bit_idx]};
    endfunction

    task automatic reg_write(logic [15:0] a, logic [7:0] d);
        addr  = a;
        wdata = d;
        wr    = 1'b1;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic read_check(string what, logic [15:0] a, logic [7:0] exp);
        addr = a;
        rd   = 1'b1;
        @(negedge clk);
        check_byte(what, exp, rdata);
        rd = 1'b0;
    endtask

    // one frame plus the first dot of the next; even cycles read LY, odd ones STAT
    task automatic run_frame(test_t t, string nm);
        int        line;
        int        dot;
        int        pix;
        int        reads;
        bit        on;
        bit        mode_known;
        ppu_mode_t exp_mode;
        on    = t.lcdc[7];
        pix   = 0;
        reads = 0;
        addr  = 16'hff44;
        rd    = 1'b1;
        for (int c = 0; c <= frame_cycles; c++) begin
            line       = on ? (c / 456) % 154 : 0;
            dot        = c % 456;
            exp_mode   = !on ? h_blank : (line >= 144 ? v_blank : scan);
            mode_known = 1'b1;
            if (dot == 0) begin
                pix   = 0;
                reads = 0;
            end
            if (vram_rd)
                reads++;
            if (px_valid) begin
                if (!(on && line < 144 && dot >= 80 && pix < 160))
                    fail_now($sformatf("%s: pixel out of the drawing window, line %0d", nm, line));
                check_px($sformatf("%s px line %0d x %0d", nm, line, pix),
                         ref_px(t, line, pix), px);
                pix++;
            end
            if (on && line < 144 && dot >= 80) begin
                // draw length varies with the fetch
                exp_mode   = (pix < 160) ? draw : h_blank;
                mode_known = pix < 160 || dot == 455;
                if (dot == 455) begin
                    check_byte({nm, " pixels per line"}, 8'd160, 8'(pix));
                    // 20 tiles of 3 reads
                    check_byte({nm, " vram reads per line"}, 8'd60, 8'(reads));
                end
            end else if (vram_rd) begin
                fail_now($sformatf("%s: VRAM read outside drawing, line %0d dot %0d",
                                   nm, line, dot));
            end
            if (mode_known)
                check_mode({nm, " mode"}, exp_mode, mode);
            check_byte({nm, " irq_vblank"}, {7'd0, on && line == 144 && dot == 0}, {7'd0, irq_vblank});
            check_byte({nm, " irq_stat"},
                       {7'd0, on && t.stat_en[6] && line == int'(t.lyc) && dot == 1},
                       {7'd0, irq_stat});
            if (c > 0 && c % 2 == 0)
                check_byte({nm, " ly"}, 8'(line), rdata);
            else if (c > 0)
                check_byte({nm, " stat"},
                           {1'b1, t.stat_en[6:3], line == int'(t.lyc), exp_mode & {2{mode_known}}},
                           rdata & {6'h3f, {2{mode_known}}});
            addr = (c % 2 == 0) ? 16'hff41 : 16'hff44;
            @(negedge clk);
        end
        rd = 1'b0;
    endtask

    initial begin
        logic [31:0] seed;
        test_t       t;
        rst   = 1'b1;
        addr  = 16'h0000;
        wr    = 1'b0;
        rd    = 1'b0;
        wdata = 8'h00;
        seed  = 32'h14d5_b95e;
        for (int i = 0; i < 8192; i++) begin
            seed    = lcg_next(seed);
            vram[i] = seed[23:16];
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;

        reg_write(16'hff42, 8'h5a);
        reg_write(16'hff43, 8'ha7);
        reg_write(16'hff45, 8'h3c);
        reg_write(16'hff47, 8'he4);
        reg_write(16'hff41, 8'hff);   // only enables 6:3 stick
        reg_write(16'hff44, 8'h77);
        reg_write(16'hff40, 8'h13);   // LCD stays off
        read_check("scy readback", 16'hff42, 8'h5a);
        read_check("scx readback", 16'hff43, 8'ha7);
        read_check("lyc readback", 16'hff45, 8'h3c);
        read_check("bgp readback", 16'hff47, 8'he4);
        read_check("stat readback", 16'hff41, 8'hf8);
        read_check("ly write ignored", 16'hff44, 8'h00);
        read_check("lcdc readback", 16'hff40, 8'h13);
        read_check("unmapped ff46", 16'hff46, 8'hff);

        for (int i = 0; i < n_tests; i++) begin
            t = tests[i];
            reg_write(16'hff43, t.scx);
            reg_write(16'hff42, t.scy);
            reg_write(16'hff45, t.lyc);
            reg_write(16'hff41, t.stat_en);
            reg_write(16'hff40, t.lcdc);   // frame timing starts here
            run_frame(t, names[i]);
            reg_write(16'hff40, 8'h00);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

//--- filelist.f
ppu_pkg.sv
ppu_regs.sv
ppu_timing.sv
ppu_bg_fetch.sv
ppu_px_shift.sv
ppu_top.sv
ppu_tb_clk.sv
ppu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module ppu_tb -o ppu_sim
out=$(./obj_dir/ppu_sim 2>&1) || true
echo "$out"
echo "$out" | grep -q "TEST OK"
